// ==== cache.f ====
cache_pkg.sv
cache_ctrl.sv
cache_store.sv
cache.sv
cache_checker.sv
tb_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert \
    --top-module tb_cache \
    --Mdir "$build_dir" \
    -f cache.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/Vtb_cache" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
    echo "FAIL: testbench reported failure, see $log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "Test completed successfully" "$log"; then
    echo "FAIL: simulation ended without a result"
    exit 1
fi

echo "PASS"
exit 0

// ==== tb_cache.sv ====
module tb_cache;
    import cache_pkg::*;

    localparam int reset_cycles   = 8;
    localparam int max_latency    = 3;
    localparam int num_directed   = 18;
    localparam int num_random     = 24;
    localparam int num_rows       = num_directed + num_random;
    localparam int timeout_cycles = num_rows * (2 * (max_latency + 2) + 2) + reset_cycles;
    localparam int model_lines    = 32;
    localparam int model_words    = model_lines * words_per_line;
    localparam logic [31:0] lfsr_seed = 32'h474d_6897;

    typedef enum logic {op_read, op_write} op_e;
    typedef enum logic [1:0] {exp_any, exp_hit, exp_clean, exp_dirty} outcome_e;

    typedef struct packed {
        op_e                    op;
        logic [proc_addr_w-1:0] addr;
        logic [word_w-1:0]      wdata;
        outcome_e               outcome;
    } row_t;

    logic                   clk = 1'b0;
    logic                   proc_reset;
    logic                   proc_read;
    logic                   proc_write;
    logic [proc_addr_w-1:0] proc_addr;
    logic [word_w-1:0]      proc_wdata;
    logic                   proc_stall;
    logic [word_w-1:0]      proc_rdata;
    logic [line_w-1:0]      mem_rdata;
    logic                   mem_ready;
    logic                   mem_read;
    logic                   mem_write;
    logic [mem_addr_w-1:0]  mem_addr;
    logic [line_w-1:0]      mem_wdata;

    row_t                  rows [num_rows];
    logic [line_w-1:0]     mem_lines [model_lines];
    logic [word_w-1:0]     ref_words [model_words];
    // expected tag directory with one entry per cache line
    logic                  res_valid [8];
    logic                  res_dirty [8];
    int                    res_tag [8];
    logic [31:0]           lfsr_state;
    int                    cycle_count = 0;
    logic                  saw_read;
    logic                  saw_write;
    logic [mem_addr_w-1:0] exp_wb_addr;
    logic [mem_addr_w-1:0] exp_alloc_addr;

    cache i_dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic row_t make_row(input op_e op, input int addr,
                                      input logic [31:0] wdata, input outcome_e outcome);
        row_t r;
        r.op      = op;
        r.addr    = proc_addr_w'(addr);
        r.wdata   = wdata;
        r.outcome = outcome;
        return r;
    endfunction

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic preload_memory();
        for (int l = 0; l < model_lines; l++) begin
            for (int w = 0; w < words_per_line; w++) begin
                mem_lines[l][w * word_w +: word_w] = rand_bits(word_w);
                ref_words[l * words_per_line + w] = mem_lines[l][w * word_w +: word_w];
            end
        end
    endtask

    task automatic build_table();
        int  tag;
        int  index;
        int  offset;
        op_e op;
        // word address = tag * 32 + index * 4 + offset
        rows[0]  = make_row(op_read,  'h00, '0, exp_clean);
        rows[1]  = make_row(op_read,  'h01, '0, exp_hit);
        rows[2]  = make_row(op_read,  'h03, '0, exp_hit);
        rows[3]  = make_row(op_write, 'h02, 32'ha5a5_0001, exp_hit);
        rows[4]  = make_row(op_read,  'h02, '0, exp_hit);
        rows[5]  = make_row(op_read,  'h01, '0, exp_hit);
        rows[6]  = make_row(op_write, 'h15, 32'h5a5a_0002, exp_clean);
        rows[7]  = make_row(op_read,  'h15, '0, exp_hit);
        rows[8]  = make_row(op_read,  'h14, '0, exp_hit);
        rows[9]  = make_row(op_read,  'h20, '0, exp_dirty);
        rows[10] = make_row(op_read,  'h02, '0, exp_clean);
        rows[11] = make_row(op_write, 'h35, 32'hc3c3_0003, exp_dirty);
        rows[12] = make_row(op_read,  'h15, '0, exp_dirty);
        rows[13] = make_row(op_read,  'h35, '0, exp_clean);
        rows[14] = make_row(op_write, 'h4f, 32'h3c3c_0004, exp_clean);
        rows[15] = make_row(op_write, 'h4c, 32'h9696_0005, exp_hit);
        rows[16] = make_row(op_read,  'h6c, '0, exp_dirty);
        rows[17] = make_row(op_read,  'h4f, '0, exp_clean);
        // random traffic on two indices with four tags each
        for (int r = num_directed; r < num_rows; r++) begin
            tag     = int'(rand_bits(2));
            index   = rand_bits(1) ? 6 : 1;
            offset  = int'(rand_bits(2));
            op      = rand_bits(1) ? op_write : op_read;
            rows[r] = make_row(op, tag * 32 + index * 4 + offset, rand_bits(32), exp_any);
        end
    endtask

    task automatic serve_memory();
        int                wait_cycles;
        int                line_addr;
        logic              is_write;
        logic [line_w-1:0] exp_line;
        is_write    = mem_write;
        line_addr   = int'(mem_addr);
        wait_cycles = int'(rand_bits(2));
        if (is_write) begin
            saw_write = 1'b1;
            assert (mem_addr == exp_wb_addr)
                else fail_check($sformatf("write-back to line 0x%0h, expected 0x%0h",
                                          mem_addr, exp_wb_addr));
            for (int w = 0; w < words_per_line; w++) begin
                exp_line[w * word_w +: word_w] = ref_words[line_addr * words_per_line + w];
            end
            assert (mem_wdata == exp_line)
                else fail_check($sformatf("write-back data 0x%h, expected 0x%h",
                                          mem_wdata, exp_line));
            mem_lines[line_addr] = mem_wdata;
        end else begin
            saw_read = 1'b1;
            assert (mem_addr == exp_alloc_addr)
                else fail_check($sformatf("allocate from line 0x%0h, expected 0x%0h",
                                          mem_addr, exp_alloc_addr));
        end
        repeat (wait_cycles) @(posedge clk);
        @(posedge clk);
        #1;
        if (!is_write) begin
            mem_rdata = mem_lines[line_addr];
        end
        mem_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_ready = 1'b0;
    endtask

    task automatic run_row(input int r);
        row_t              row;
        int                line_addr;
        int                index;
        int                tag;
        int                cycles;
        outcome_e          expected;
        logic              first_stall;
        logic              stalled;
        logic [word_w-1:0] rdata;
        row       = rows[r];
        line_addr = int'(row.addr) / words_per_line;
        index     = line_addr % 8;
        tag       = line_addr / 8;
        if (res_valid[index] && res_tag[index] == tag) begin
            expected = exp_hit;
        end else if (res_valid[index] && res_dirty[index]) begin
            expected = exp_dirty;
        end else begin
            expected = exp_clean;
        end
        assert (row.outcome == exp_any || row.outcome == expected)
            else fail_check($sformatf("row %0d table outcome %s, tag model gives %s",
                                      r, row.outcome.name(), expected.name()));
        exp_wb_addr    = mem_addr_w'(res_tag[index] * 8 + index);
        exp_alloc_addr = mem_addr_w'(line_addr);
        saw_read       = 1'b0;
        saw_write      = 1'b0;
        proc_read      = (row.op == op_read);
        proc_write     = (row.op == op_write);
        proc_addr      = row.addr;
        proc_wdata     = row.wdata;
        // hold the request until stall is low before an edge
        cycles      = 0;
        first_stall = 1'b0;
        do begin
            @(negedge clk);
            if (cycles == 0) begin
                first_stall = proc_stall;
            end
            cycles  = cycles + 1;
            stalled = proc_stall;
            if (stalled) begin
                @(posedge clk);
            end
        end while (stalled);
        rdata = proc_rdata;
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        case (expected)
            exp_hit: assert (!first_stall && !saw_read && !saw_write)
                else fail_check($sformatf("row %0d expected a hit without stall", r));
            exp_clean: assert (first_stall && saw_read && !saw_write)
                else fail_check($sformatf("row %0d expected an allocate only", r));
            default: assert (first_stall && saw_read && saw_write)
                else fail_check($sformatf("row %0d expected write-back then allocate", r));
        endcase
        if (expected != exp_hit) begin
            res_valid[index] = 1'b1;
            res_tag[index]   = tag;
            res_dirty[index] = 1'b0;
        end
        if (row.op == op_write) begin
            res_dirty[index]     = 1'b1;
            ref_words[row.addr] = row.wdata;
        end else begin
            assert (rdata == ref_words[row.addr])
                else fail_check($sformatf("row %0d read of 0x%0h gave 0x%08h, expected 0x%08h",
                                          r, row.addr, rdata, ref_words[row.addr]));
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (proc_reset && (mem_read || mem_write)) begin
                serve_memory();
            end
        end
    end

    initial begin
        proc_reset = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        lfsr_state = lfsr_seed;
        preload_memory();
        build_table();
        for (int i = 0; i < 8; i++) begin
            res_valid[i] = 1'b0;
            res_dirty[i] = 1'b0;
            res_tag[i]   = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        proc_reset = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        if (i_dut.i_checker.assert_failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Protocol checker flagged %0d assertion failures",
                     i_dut.i_checker.assert_failures);
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== cache_checker.sv ====
module cache_checker (
    input logic clk,
    input logic proc_reset,
    input logic proc_stall,
    input logic mem_read,
    input logic mem_write
);

    int assert_failures = 0;

    // one memory phase at a time
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!proc_reset) !(mem_read && mem_write))
        else begin
            assert_failures = assert_failures + 1;
            $error("mem_read and mem_write are high together");
        end

    // memory traffic only happens during a miss
    strobes_need_stall: assert property (
        @(posedge clk) disable iff (!proc_reset) (mem_read || mem_write) |-> proc_stall)
        else begin
            assert_failures = assert_failures + 1;
            $error("memory strobe high while proc_stall is low");
        end

    // reset puts the controller back in idle
    strobes_low_in_reset: assert property (
        @(posedge clk) !proc_reset |=> (!mem_read && !mem_write))
        else begin
            assert_failures = assert_failures + 1;
            $error("memory strobe high during reset");
        end

endmodule

bind cache cache_checker i_checker (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_stall (proc_stall),
    .mem_read   (mem_read),
    .mem_write  (mem_write)
);

// ==== cache.sv ====
module cache (
    input  logic                              clk,
    input  logic                              proc_reset,
    // processor side
    input  logic                              proc_read,
    input  logic                              proc_write,
    input  logic [cache_pkg::proc_addr_w-1:0] proc_addr,
    input  logic [cache_pkg::word_w-1:0]      proc_wdata,
    output logic                              proc_stall,
    output logic [cache_pkg::word_w-1:0]      proc_rdata,
    // memory side
    input  logic [cache_pkg::line_w-1:0]      mem_rdata,
    input  logic                              mem_ready,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic [cache_pkg::mem_addr_w-1:0]  mem_addr,
    output logic [cache_pkg::line_w-1:0]      mem_wdata
);
    import cache_pkg::*;

    cache_addr_t       addr;
    line_status_t      status;
    store_cmd_t        cmd;
    logic [tag_w-1:0]  victim_tag;

    // tag | index | offset
    assign addr = cache_addr_t'(proc_addr);

    // write-back goes to the victim's line, allocate to the requested one
    assign mem_addr = mem_write ? {victim_tag, addr.index} : {addr.tag, addr.index};

    cache_ctrl i_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .status     (status),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .cmd        (cmd)
    );

    cache_store i_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (addr),
        .cmd        (cmd),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .status     (status),
        .proc_rdata (proc_rdata),
        .mem_wdata  (mem_wdata),
        .victim_tag (victim_tag)
    );

endmodule

// ==== cache_store.sv ====
module cache_store (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  cache_pkg::cache_addr_t        addr,
    input  cache_pkg::store_cmd_t         cmd,
    input  logic [cache_pkg::word_w-1:0]  proc_wdata,
    input  logic [cache_pkg::line_w-1:0]  mem_rdata,
    output cache_pkg::line_status_t       status,
    output logic [cache_pkg::word_w-1:0]  proc_rdata,
    output logic [cache_pkg::line_w-1:0]  mem_wdata,
    output logic [cache_pkg::tag_w-1:0]   victim_tag
);
    import cache_pkg::*;

    // line storage
    logic [line_w-1:0]    data_q [num_lines];
    logic [tag_w-1:0]     tag_q  [num_lines];
    logic [num_lines-1:0] valid_q;
    logic [num_lines-1:0] dirty_q;

    // indexed line
    logic [line_w-1:0] cur_line;
    logic [tag_w-1:0]  cur_tag;
    logic [line_w-1:0] merged_line;

    assign cur_line = data_q[addr.index];
    assign cur_tag  = tag_q[addr.index];

    // hit detection
    // hit is the raw tag match without the valid bit
    always_comb begin
        status.valid = valid_q[addr.index];
        status.hit   = (cur_tag == addr.tag);
        status.dirty = dirty_q[addr.index];
    end

    // read side
    assign proc_rdata = cur_line[addr.offset * word_w +: word_w];
    assign mem_wdata  = cur_line;
    assign victim_tag = cur_tag;

    // replace the addressed word, keep the rest of the line
    always_comb begin
        merged_line = cur_line;
        for (int w = 0; w < words_per_line; w++) begin
            if (addr.offset == offset_w'(w)) begin
                merged_line[w * word_w +: word_w] = proc_wdata;
            end
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (!proc_reset) begin
            for (int i = 0; i < num_lines; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else if (cmd.fill) begin
            data_q[addr.index] <= mem_rdata;
            tag_q[addr.index]  <= addr.tag;
        end else if (cmd.word_write) begin
            data_q[addr.index] <= merged_line;
        end
    end

    // valid bits
    // only a fill makes a line valid
    always_ff @(posedge clk) begin
        if (!proc_reset) begin
            valid_q <= '0;
        end else if (cmd.fill) begin
            valid_q[addr.index] <= 1'b1;
        end
    end

    // dirty bits
    // the fill that follows a write-back leaves the line clean
    always_ff @(posedge clk) begin
        if (!proc_reset) begin
            dirty_q <= '0;
        end else if (cmd.fill) begin
            dirty_q[addr.index] <= 1'b0;
        end else if (cmd.word_write) begin
            dirty_q[addr.index] <= 1'b1;
        end
    end

endmodule

// ==== cache_ctrl.sv ====
module cache_ctrl (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  logic                     proc_read,
    input  logic                     proc_write,
    input  cache_pkg::line_status_t  status,
    input  logic                     mem_ready,
    output logic                     proc_stall,
    output logic                     mem_read,
    output logic                     mem_write,
    output cache_pkg::store_cmd_t    cmd
);
    import cache_pkg::*;

    cache_state_e state;
    cache_state_e state_nxt;
    logic         req;
    logic         line_hit;

    assign req      = proc_read | proc_write;
    assign line_hit = status.valid & status.hit;

    always_ff @(posedge clk) begin
        if (!proc_reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        unique case (state)
            st_idle: begin
                if (req && !line_hit) begin
                    // a dirty victim has to go out before the new line comes in
                    if (status.valid && status.dirty) begin
                        state_nxt = st_write_back;
                    end else begin
                        state_nxt = st_allocate;
                    end
                end
            end
            st_write_back: begin
                if (mem_ready) begin
                    state_nxt = st_allocate;
                end
            end
            st_allocate: begin
                if (mem_ready) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // strobes and store commands
    always_comb begin
        proc_stall     = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        cmd.fill       = 1'b0;
        cmd.word_write = 1'b0;
        unique case (state)
            st_idle: begin
                proc_stall     = req & ~line_hit;
                cmd.word_write = proc_write & line_hit;
            end
            st_write_back: begin
                proc_stall = 1'b1;
                mem_write  = 1'b1;
            end
            st_allocate: begin
                proc_stall = 1'b1;
                mem_read   = 1'b1;
                // line is taken from memory on the ready cycle only
                cmd.fill   = mem_ready;
            end
            default: begin
                proc_stall = 1'b0;
            end
        endcase
    end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // processor side
    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int proc_addr_w    = 30;

    // line geometry
    localparam int line_w    = word_w * words_per_line;
    localparam int num_lines = 8;

    // address map: tag | index | offset
    localparam int offset_w   = 2;
    localparam int index_w    = 3;
    localparam int tag_w      = proc_addr_w - index_w - offset_w;
    localparam int mem_addr_w = proc_addr_w - offset_w;

    // miss handling states
    typedef enum logic [1:0] {
        st_idle       = 2'b00,
        st_write_back = 2'b01,
        st_allocate   = 2'b10
    } cache_state_e;

    // decoded processor word address
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } cache_addr_t;

    // state of the indexed line
    typedef struct packed {
        logic valid;
        logic hit;
        logic dirty;
    } line_status_t;

    // fill loads a whole line from memory and leaves it clean,
    // word_write merges one processor word and marks the line dirty
    typedef struct packed {
        logic fill;
        logic word_write;
    } store_cmd_t;

endpackage
